/* src/trace_pkg.sv */
package trace_pkg;

   localparam int NIBBLE_W    = 4;             // trace port width
   localparam int BUFFER_W    = 32;            // window holds 8 nibbles
   localparam int NUM_RULES   = 4;
   localparam int COUNT_W     = 8;             // saturating hit counter
   localparam int TS_W        = 16;
   localparam int FIFO_DEPTH  = 16;
   localparam int FIFO_ADDR_W = 4;
   localparam int REG_ADDR_W  = 8;
   localparam int REG_DATA_W  = 32;
   localparam int DELAY_W     = 16;            // trig delay/width and capture length

   typedef logic [BUFFER_W-1:0]  trace_word_t;  // window, pattern or mask
   typedef logic [NUM_RULES-1:0] rule_vec_t;    // one bit per rule
   typedef logic [COUNT_W-1:0]   hit_count_t;

   // capture record, timestamp on top
   typedef struct packed {
      logic [TS_W-1:0] ts;
      rule_vec_t       hits;
   } fifo_entry_t;

   typedef enum logic [REG_ADDR_W-1:0] {
      ADDR_CTRL       = 8'h00,                 // bit0 arm, bit1 trig enable
      ADDR_STATUS     = 8'h01,                 // read only
      ADDR_RULE_EN    = 8'h02,
      ADDR_CAP_LEN    = 8'h03,
      ADDR_TRIG_DELAY = 8'h04,
      ADDR_TRIG_WIDTH = 8'h05,
      ADDR_PATTERN0   = 8'h10,                 // 4 patterns from here
      ADDR_MASK0      = 8'h14,                 // 4 masks
      ADDR_COUNT0     = 8'h18,                 // 4 hit counters
      ADDR_FIFO_DATA  = 8'h20                  // read pops the fifo
   } reg_addr_e;

   typedef enum logic [1:0] {
      cap_idle,
      cap_run,
      cap_done
   } capture_state_e;

   typedef enum logic [1:0] {
      trig_idle,
      trig_wait,
      trig_pulse,
      trig_done
   } trig_state_e;

endpackage

/* src/trace_matcher.sv */
module trace_matcher import trace_pkg::*; (
   input  logic                trace_clk,
   input  logic                reset,
   input  logic                trcena,
   input  logic [NIBBLE_W-1:0] tracedata,
   input  rule_vec_t           rule_en,
   input  trace_word_t         patterns [NUM_RULES],
   input  trace_word_t         masks [NUM_RULES],
   output rule_vec_t           hits,
   output logic                hit_strobe,
   output hit_count_t          counts [NUM_RULES]
);

   trace_word_t window;                        // newest nibble at the bottom
   logic [3:0]  fill;                          // nibbles shifted in up to 8
   logic        eval;                          // last edge shifted a valid window
   rule_vec_t   match;                         // combinational rule results

   // one nibble in per enabled edge
   always_ff @(posedge trace_clk) begin
      if (trcena) begin
         window <= {window[BUFFER_W-NIBBLE_W-1:0], tracedata};
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         fill <= '0;
         eval <= 1'b0;
      end else begin
         if (trcena && fill != 4'(BUFFER_W / NIBBLE_W)) begin
            fill <= fill + 1'b1;
         end
         // this shift leaves 8 good nibbles in the window
         eval <= trcena && (fill >= 4'(BUFFER_W / NIBBLE_W - 1));
      end
   end

   // masked compare per rule
   for (genvar i = 0; i < NUM_RULES; i++) begin : g_rule
      assign match[i] = rule_en[i] && ((window & masks[i]) == (patterns[i] & masks[i]));
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         hits       <= '0;
         hit_strobe <= 1'b0;
      end else begin
         hit_strobe <= eval;                   // one cycle per evaluated shift
         if (eval) begin
            hits <= match;                     // held until next strobe
         end
      end
   end

   // saturating counters bump on the strobe edge
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_RULES; i++) begin
            counts[i] <= '0;
         end
      end else if (eval) begin
         for (int i = 0; i < NUM_RULES; i++) begin
            if (match[i] && counts[i] != '1) begin
               counts[i] <= counts[i] + 1'b1;  // stick at 255
            end
         end
      end
   end

endmodule

/* src/capture_ctrl.sv */
module capture_ctrl import trace_pkg::*; (
   input  logic               trace_clk,
   input  logic               reset,
   input  logic               arm_pulse,
   input  logic               hit_strobe,
   input  rule_vec_t          hits,
   input  logic [DELAY_W-1:0] cap_len,
   input  logic               fifo_full,
   output logic               fifo_push,
   output fifo_entry_t        fifo_wdata,
   output capture_state_e     cap_state,
   output logic               overflow
);

   logic [TS_W-1:0]    timestamp;              // cycles since arm
   logic [DELAY_W-1:0] rec_cnt;                // records actually written
   logic               limit_hit;              // length reached
   logic               record;                 // a record is due this cycle

   assign limit_hit = rec_cnt >= cap_len;
   assign record    = (cap_state == cap_run) && !limit_hit && hit_strobe && (|hits);

   // write goes on the same edge as the strobe
   assign fifo_push       = record && !fifo_full;
   assign fifo_wdata.ts   = timestamp;
   assign fifo_wdata.hits = hits;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         cap_state <= cap_idle;
         timestamp <= '0;
         rec_cnt   <= '0;
         overflow  <= 1'b0;
      end else if (arm_pulse) begin
         // arm restarts from any state
         cap_state <= cap_run;
         timestamp <= '0;
         rec_cnt   <= '0;
         overflow  <= 1'b0;
      end else if (cap_state == cap_run) begin
         timestamp <= timestamp + 1'b1;        // free running while capturing
         if (limit_hit) begin
            cap_state <= cap_done;             // cap_len 0 ends right away
         end
         if (fifo_push) begin
            rec_cnt <= rec_cnt + 1'b1;
         end
         if (record && fifo_full) begin
            overflow <= 1'b1;                  // record lost, sticky till arm
         end
      end
   end

endmodule

/* src/trace_fifo.sv */
module trace_fifo import trace_pkg::*; (
   input  logic        trace_clk,
   input  logic        reset,
   input  logic        push,
   input  fifo_entry_t wdata,
   input  logic        pop,
   output fifo_entry_t rdata,
   output logic        empty,
   output logic        full
);

   fifo_entry_t            mem [FIFO_DEPTH];   // record storage
   logic [FIFO_ADDR_W-1:0] wr_ptr;
   logic [FIFO_ADDR_W-1:0] rd_ptr;
   logic [FIFO_ADDR_W:0]   count;              // occupancy 0..16
   logic                   do_push;
   logic                   do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;             // pop on empty is dropped

   always_ff @(posedge trace_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                         // both or neither
         endcase
      end
   end

   assign rdata = mem[rd_ptr];                 // head shows without a pop
   assign empty = (count == '0);
   assign full  = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));

endmodule

/* src/pulse_trigger.sv */
module pulse_trigger import trace_pkg::*; (
   input  logic               trace_clk,
   input  logic               reset,
   input  logic               trig_enable,
   input  logic               arm_pulse,
   input  logic               hit_strobe,
   input  rule_vec_t          hits,
   input  logic [DELAY_W-1:0] trig_delay,
   input  logic [DELAY_W-1:0] trig_width,
   output logic               trig_out
);

   trig_state_e        state;
   trig_state_e        state_nxt;
   trig_state_e        pulse_st;               // where the delay leads
   logic [DELAY_W-1:0] cnt;                    // delay then width countdown
   logic [DELAY_W-1:0] cnt_nxt;
   logic               fire;

   assign fire     = trig_enable && hit_strobe && (|hits);
   assign pulse_st = (trig_width != '0) ? trig_pulse : trig_done; // width 0 skips pulse

   always_comb begin
      state_nxt = state;
      cnt_nxt   = cnt;
      case (state)
         trig_idle: if (fire) begin
            if (trig_delay != '0) begin
               state_nxt = trig_wait;
               cnt_nxt   = trig_delay;
            end else begin
               state_nxt = pulse_st;           // no delay, pulse next cycle
               cnt_nxt   = trig_width;
            end
         end
         trig_wait: if (cnt == DELAY_W'(1)) begin
            state_nxt = pulse_st;
            cnt_nxt   = trig_width;
         end else begin
            cnt_nxt = cnt - 1'b1;
         end
         trig_pulse: if (cnt == DELAY_W'(1)) begin
            state_nxt = trig_done;             // one shot, wait for re-arm
         end else begin
            cnt_nxt = cnt - 1'b1;
         end
         default: ;                            // trig_done holds
      endcase
      if (arm_pulse) state_nxt = trig_idle;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= trig_idle;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         cnt   <= cnt_nxt;
      end
   end

   assign trig_out = (state == trig_pulse);

endmodule

/* src/trace_regs.sv */
module trace_regs import trace_pkg::*; (
   input  logic                  trace_clk,
   input  logic                  reset,
   input  reg_addr_e             reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic                  reg_write,
   input  logic                  reg_read,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_rvalid,
   output rule_vec_t             rule_en,
   output trace_word_t           patterns [NUM_RULES],
   output trace_word_t           masks [NUM_RULES],
   output logic [DELAY_W-1:0]    cap_len,
   output logic                  trig_enable,
   output logic [DELAY_W-1:0]    trig_delay,
   output logic [DELAY_W-1:0]    trig_width,
   output logic                  arm_pulse,
   input  hit_count_t            counts [NUM_RULES],
   input  capture_state_e        cap_state,
   input  logic                  overflow,
   input  fifo_entry_t           fifo_rdata,
   input  logic                  fifo_empty,
   output logic                  fifo_pop
);

   logic [REG_ADDR_W-1:0]        base;         // address with rule index cleared
   logic [$clog2(NUM_RULES)-1:0] idx;          // rule index within a bank
   logic                         is_pattern;
   logic                         is_mask;
   logic                         is_count;
   logic [REG_DATA_W-1:0]        rd_mux;

   assign base       = reg_addr & ~REG_ADDR_W'(NUM_RULES - 1);
   assign idx        = reg_addr[$clog2(NUM_RULES)-1:0];
   assign is_pattern = (base == ADDR_PATTERN0);
   assign is_mask    = (base == ADDR_MASK0);
   assign is_count   = (base == ADDR_COUNT0);
   assign fifo_pop   = reg_read && (reg_addr == ADDR_FIFO_DATA); // head leaves as it is read

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rule_en     <= '0;
         cap_len     <= '0;
         trig_enable <= 1'b0;
         trig_delay  <= '0;
         trig_width  <= '0;
         arm_pulse   <= 1'b0;
         for (int i = 0; i < NUM_RULES; i++) begin
            patterns[i] <= '0;
            masks[i]    <= '0;
         end
      end else begin
         arm_pulse <= reg_write && (reg_addr == ADDR_CTRL) && reg_wdata[0]; // single cycle
         if (reg_write) begin
            if (is_pattern) begin
               patterns[idx] <= reg_wdata;
            end else if (is_mask) begin
               masks[idx] <= reg_wdata;
            end else begin
               case (reg_addr)
                  ADDR_CTRL:       trig_enable <= reg_wdata[1];
                  ADDR_RULE_EN:    rule_en     <= reg_wdata[NUM_RULES-1:0];
                  ADDR_CAP_LEN:    cap_len     <= reg_wdata[DELAY_W-1:0];
                  ADDR_TRIG_DELAY: trig_delay  <= reg_wdata[DELAY_W-1:0];
                  ADDR_TRIG_WIDTH: trig_width  <= reg_wdata[DELAY_W-1:0];
                  default: ;                   // status, counters, fifo are read only
               endcase
            end
         end
      end
   end

   // read mux, everything zero extended
   always_comb begin
      rd_mux = '0;
      if (is_pattern) begin
         rd_mux = patterns[idx];
      end else if (is_mask) begin
         rd_mux = masks[idx];
      end else if (is_count) begin
         rd_mux[COUNT_W-1:0] = counts[idx];
      end else begin
         case (reg_addr)
            ADDR_CTRL:       rd_mux[1] = trig_enable; // arm bit reads 0
            ADDR_STATUS:     rd_mux[3:0] = {overflow, fifo_empty, cap_state};
            ADDR_RULE_EN:    rd_mux[NUM_RULES-1:0] = rule_en;
            ADDR_CAP_LEN:    rd_mux[DELAY_W-1:0] = cap_len;
            ADDR_TRIG_DELAY: rd_mux[DELAY_W-1:0] = trig_delay;
            ADDR_TRIG_WIDTH: rd_mux[DELAY_W-1:0] = trig_width;
            ADDR_FIFO_DATA:  if (!fifo_empty) rd_mux[$bits(fifo_entry_t)-1:0] = fifo_rdata;
            default: ;                         // unmapped reads 0
         endcase
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_read;               // data one cycle after the request
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reg_read) reg_rdata <= rd_mux;
   end

endmodule

/* src/trace_sniffer_top.sv */
module trace_sniffer_top import trace_pkg::*; (
   input  logic                  trace_clk,
   input  logic                  reset,
   input  logic                  trcena,
   input  logic [NIBBLE_W-1:0]   tracedata,
   output logic                  trig_out,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic                  reg_write,
   input  logic                  reg_read,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_rvalid
);

   // configuration from the register block
   rule_vec_t          rule_en;
   trace_word_t        patterns [NUM_RULES];
   trace_word_t        masks [NUM_RULES];
   logic [DELAY_W-1:0] cap_len;
   logic               trig_enable;
   logic [DELAY_W-1:0] trig_delay;
   logic [DELAY_W-1:0] trig_width;
   logic               arm_pulse;

   // matcher results
   rule_vec_t          hits;
   logic               hit_strobe;
   hit_count_t         counts [NUM_RULES];

   // capture path
   logic               fifo_push;
   logic               fifo_pop;
   fifo_entry_t        fifo_wdata;
   fifo_entry_t        fifo_rdata;
   logic               fifo_empty;
   logic               fifo_full;
   capture_state_e     cap_state;
   logic               overflow;

   trace_matcher u_matcher (
      .trace_clk (trace_clk),  .reset      (reset),
      .trcena    (trcena),     .tracedata  (tracedata),
      .rule_en   (rule_en),    .patterns   (patterns),
      .masks     (masks),      .hits       (hits),
      .hit_strobe(hit_strobe), .counts     (counts)
   );

   capture_ctrl u_capture (
      .trace_clk (trace_clk),  .reset      (reset),
      .arm_pulse (arm_pulse),  .hit_strobe (hit_strobe),
      .hits      (hits),       .cap_len    (cap_len),
      .fifo_full (fifo_full),  .fifo_push  (fifo_push),
      .fifo_wdata(fifo_wdata), .cap_state  (cap_state),
      .overflow  (overflow)
   );

   trace_fifo u_fifo (
      .trace_clk (trace_clk),  .reset      (reset),
      .push      (fifo_push),  .wdata      (fifo_wdata),
      .pop       (fifo_pop),   .rdata      (fifo_rdata),
      .empty     (fifo_empty), .full       (fifo_full)
   );

   pulse_trigger u_trigger (
      .trace_clk  (trace_clk),   .reset      (reset),
      .trig_enable(trig_enable), .arm_pulse  (arm_pulse),
      .hit_strobe (hit_strobe),  .hits       (hits),
      .trig_delay (trig_delay),  .trig_width (trig_width),
      .trig_out   (trig_out)
   );

   trace_regs u_regs (
      .trace_clk  (trace_clk),            .reset      (reset),
      .reg_addr   (reg_addr_e'(reg_addr)), .reg_wdata  (reg_wdata),
      .reg_write  (reg_write),            .reg_read   (reg_read),
      .reg_rdata  (reg_rdata),            .reg_rvalid (reg_rvalid),
      .rule_en    (rule_en),              .patterns   (patterns),
      .masks      (masks),                .cap_len    (cap_len),
      .trig_enable(trig_enable),          .trig_delay (trig_delay),
      .trig_width (trig_width),           .arm_pulse  (arm_pulse),
      .counts     (counts),               .cap_state  (cap_state),
      .overflow   (overflow),             .fifo_rdata (fifo_rdata),
      .fifo_empty (fifo_empty),           .fifo_pop   (fifo_pop)
   );

endmodule

/* tb/trace_sniffer_checker.sv */
module trace_sniffer_checker import trace_pkg::*; (
   input logic trace_clk,
   input logic reset,
   input logic trig_out,
   input logic fifo_push,
   input logic fifo_full,
   input logic hit_strobe,
   input logic reg_read,
   input logic reg_rvalid
);
   timeunit 1ns;
   timeprecision 1ps;

   // trigger held low while in reset
   a_trig_reset: assert property (@(posedge trace_clk) reset |=> !trig_out)
      else $error("trig_out high during reset");

   a_push_full: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_push |-> !fifo_full)
      else $error("fifo push while full");

   // strobes stay single cycle under gapped trcena
   a_strobe_gap: assert property (@(posedge trace_clk) disable iff (reset)
      hit_strobe |=> !hit_strobe)
      else $error("hit_strobe high two cycles in a row");

   a_rvalid: assert property (@(posedge trace_clk) disable iff (reset)
      reg_rvalid == $past(reg_read))
      else $error("reg_rvalid does not follow reg_read");

endmodule

bind trace_sniffer_top trace_sniffer_checker u_checker (.*);

/* tb/tb_trace_sniffer.sv */
module tb_trace_sniffer import trace_pkg::*; ;
   timeunit 1ns;
   timeprecision 1ps;

   logic                  trace_clk;
   logic                  reset;
   logic                  trcena;
   logic [NIBBLE_W-1:0]   tracedata;
   logic                  trig_out;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic [REG_DATA_W-1:0] reg_wdata;
   logic                  reg_write;
   logic                  reg_read;
   logic [REG_DATA_W-1:0] reg_rdata;
   logic                  reg_rvalid;

   integer      seed = 118;
   int          err_value = 0;                 // wrong values
   int          err_other = 0;                 // timeouts and protocol trouble
   trace_word_t ref_window = '0;               // model of the trace window
   int          ref_fill = 0;                  // shifts since reset
   trace_word_t ref_pat [NUM_RULES];
   trace_word_t ref_mask [NUM_RULES];
   rule_vec_t   ref_en = '0;
   hit_count_t  ref_cnt [NUM_RULES];
   rule_vec_t   exp_hits [$];                  // one per evaluated shift
   rule_vec_t   exp_rec [$];                   // nonzero hit vectors in order
   rule_vec_t   strobe_exp;
   logic        trig_prev = 1'b0;
   int          trig_rises = 0;

   trace_sniffer_top dut (.*);

   initial begin
      trace_clk = 1'b0;
      forever #4 trace_clk = ~trace_clk;       // 8 ns period
   end

   function automatic trace_word_t window_next(trace_word_t w, logic [NIBBLE_W-1:0] nib);
      return {w[BUFFER_W-NIBBLE_W-1:0], nib};
   endfunction

   function automatic rule_vec_t rule_hits(trace_word_t w);
      rule_vec_t h;
      for (int i = 0; i < NUM_RULES; i++)
         h[i] = ref_en[i] && ((w & ref_mask[i]) == (ref_pat[i] & ref_mask[i]));
      return h;
   endfunction

   function automatic hit_count_t count_next(hit_count_t c, logic hit);
      return (hit && c != 8'hFF) ? c + 1'b1 : c;
   endfunction

   task automatic check_word(string name, logic [REG_DATA_W-1:0] exp, logic [REG_DATA_W-1:0] got);
      if (exp !== got) begin
         $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
         err_value++;
      end
   endtask

   task automatic check_count(string name, hit_count_t exp, hit_count_t got);
      if (exp !== got) begin
         $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, got);
         err_value++;
      end
   endtask

   task automatic check_entry(string name, rule_vec_t exp, fifo_entry_t got);
      if (exp !== got.hits) begin
         $display("ERROR %0t %s expected %b got %b", $time, name, exp, got.hits);
         err_value++;
      end
   endtask

   task automatic check_hits(string name, rule_vec_t exp, rule_vec_t got);
      if (exp !== got) begin
         $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
         err_value++;
      end
   endtask

   task automatic check_state(string name, capture_state_e exp, capture_state_e got);
      if (exp !== got) begin
         $display("ERROR %0t %s expected %s got %s", $time, name, exp.name(), got.name());
         err_value++;
      end
   endtask

   task automatic reg_wr(logic [REG_ADDR_W-1:0] a, logic [REG_DATA_W-1:0] d);
      @(posedge trace_clk);
      reg_addr  <= a;
      reg_wdata <= d;
      reg_write <= 1'b1;
      @(posedge trace_clk);
      reg_write <= 1'b0;
   endtask

   task automatic reg_rd(logic [REG_ADDR_W-1:0] a, output logic [REG_DATA_W-1:0] d);
      int n;
      n = 0;
      @(posedge trace_clk);
      reg_addr <= a;
      reg_read <= 1'b1;
      @(posedge trace_clk);
      reg_read <= 1'b0;
      @(negedge trace_clk);
      while (!reg_rvalid && n < 10) begin
         @(negedge trace_clk);
         n++;
      end
      if (!reg_rvalid) begin
         $display("register read of address %h got no response", a);
         err_other++;
      end
      d = reg_rdata;
   endtask

   task automatic set_rule(int i, trace_word_t p, trace_word_t m);
      reg_wr(ADDR_PATTERN0 + i, p);
      reg_wr(ADDR_MASK0 + i, m);
      ref_pat[i]  = p;
      ref_mask[i] = m;
   endtask

   // one nibble with trcena as given then an idle cycle
   task automatic shift_nibble(logic en, logic [NIBBLE_W-1:0] nib);
      rule_vec_t h;
      @(posedge trace_clk);
      trcena    <= en;
      tracedata <= nib;
      if (en) begin
         ref_window = window_next(ref_window, nib);
         ref_fill++;
         if (ref_fill >= 8) begin
            h = rule_hits(ref_window);
            exp_hits.push_back(h);
            for (int i = 0; i < NUM_RULES; i++) ref_cnt[i] = count_next(ref_cnt[i], h[i]);
         end
      end
      @(posedge trace_clk);
      trcena <= 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_hits.size() != 0 && n < 50) begin
         @(negedge trace_clk);
         n++;
      end
      if (exp_hits.size() != 0) begin
         $display("hit strobes missing, %0d shifts never evaluated", exp_hits.size());
         err_other++;
      end
   endtask

   task automatic wait_state(capture_state_e s);
      logic [REG_DATA_W-1:0] st;
      int                    n;
      n = 0;
      reg_rd(ADDR_STATUS, st);
      while (st[1:0] != s && n < 20) begin
         reg_rd(ADDR_STATUS, st);
         n++;
      end
      if (st[1:0] != s) begin
         $display("capture never reached state %s", s.name());
         err_other++;
      end
      check_state("cap_state", s, capture_state_e'(st[1:0]));
   endtask

   // compare each strobe against the model
   always @(negedge trace_clk) begin
      if (!reset && dut.hit_strobe) begin
         if (exp_hits.size() == 0) begin
            $display("hit strobe came without a pending shift");
            err_other++;
         end else begin
            strobe_exp = exp_hits.pop_front();
            check_hits("hits", strobe_exp, dut.hits);
            if (|strobe_exp) exp_rec.push_back(strobe_exp);
         end
      end
      if (trig_out && !trig_prev) trig_rises++;
      trig_prev = trig_out;
   end

   initial begin
      logic [REG_DATA_W-1:0] d;
      fifo_entry_t           rec;
      logic [TS_W-1:0]       last_ts;
      int                    n;
      reset     = 1'b1;
      trcena    = 1'b0;
      tracedata = '0;
      reg_addr  = '0;
      reg_wdata = '0;
      reg_write = 1'b0;
      reg_read  = 1'b0;
      for (int i = 0; i < NUM_RULES; i++) begin
         ref_pat[i]  = '0;
         ref_mask[i] = '0;
         ref_cnt[i]  = '0;
      end
      repeat (10) @(posedge trace_clk);
      reset <= 1'b0;

      // register readback
      for (int i = 0; i < NUM_RULES; i++) begin
         reg_wr(ADDR_PATTERN0 + i, 32'hA5C3_0F10 ^ (i * 32'h0101_1111));
         reg_wr(ADDR_MASK0 + i, 32'h0FF0_F00F << i);
      end
      for (int i = 0; i < NUM_RULES; i++) begin    // whole bank written first
         reg_rd(ADDR_PATTERN0 + i, d);
         check_word("pattern", 32'hA5C3_0F10 ^ (i * 32'h0101_1111), d);
         reg_rd(ADDR_MASK0 + i, d);
         check_word("mask", 32'h0FF0_F00F << i, d);
      end
      reg_wr(ADDR_RULE_EN, 32'hA);
      reg_rd(ADDR_RULE_EN, d);
      check_word("rule_en", 32'hA, d);
      reg_wr(ADDR_CAP_LEN, 32'h1234);
      reg_rd(ADDR_CAP_LEN, d);
      check_word("cap_len", 32'h1234, d);
      reg_wr(ADDR_TRIG_DELAY, 32'h55);
      reg_rd(ADDR_TRIG_DELAY, d);
      check_word("trig_delay", 32'h55, d);
      reg_wr(ADDR_TRIG_WIDTH, 32'h9);
      reg_rd(ADDR_TRIG_WIDTH, d);
      check_word("trig_width", 32'h9, d);
      reg_rd(8'h30, d);
      check_word("unmapped", 32'h0, d);

      // hit counting on random nibbles with rule 3 off
      set_rule(0, 32'h5, 32'hF);
      set_rule(1, 32'hA03, 32'hF0F);
      set_rule(2, 32'h4, 32'hC);
      set_rule(3, 32'h0, 32'h0);
      reg_wr(ADDR_RULE_EN, 32'h7);
      ref_en = 4'h7;
      for (int k = 0; k < 200; k++) shift_nibble(($random(seed) & 3) != 0, $random(seed));
      drain();
      for (int i = 0; i < NUM_RULES; i++) begin
         reg_rd(ADDR_COUNT0 + i, d);
         check_count("count", ref_cnt[i], d[COUNT_W-1:0]);
      end

      // capture of 5 records
      set_rule(0, 32'hA, 32'hF);
      reg_wr(ADDR_RULE_EN, 32'h1);
      ref_en = 4'h1;
      reg_wr(ADDR_CAP_LEN, 5);
      exp_rec.delete();
      reg_wr(ADDR_CTRL, 32'h1);
      wait_state(cap_run);
      for (int k = 0; k < 30; k++) shift_nibble(1'b1, (k % 3 == 0) ? 4'hA : 4'(k % 3));
      drain();
      wait_state(cap_done);
      reg_rd(ADDR_STATUS, d);
      check_word("status", 32'h2, d);
      last_ts = '0;
      for (int k = 0; k < 5; k++) begin
         reg_rd(ADDR_FIFO_DATA, d);
         rec = fifo_entry_t'(d[$bits(fifo_entry_t)-1:0]);
         check_entry("fifo hits", exp_rec[k], rec);
         if (k > 0 && rec.ts <= last_ts) begin
            $display("ERROR %0t fifo ts expected above %h got %h", $time, last_ts, rec.ts);
            err_value++;
         end
         last_ts = rec.ts;
      end
      reg_rd(ADDR_FIFO_DATA, d);
      check_word("fifo_data empty", 32'h0, d);
      reg_rd(ADDR_STATUS, d);
      check_word("status", 32'h6, d);

      // overflow with more than 16 matches
      reg_wr(ADDR_CAP_LEN, 40);
      exp_rec.delete();
      reg_wr(ADDR_CTRL, 32'h1);
      wait_state(cap_run);
      for (int k = 0; k < 60; k++) shift_nibble(1'b1, (k % 3 == 0) ? 4'hA : 4'(k % 3));
      drain();
      reg_rd(ADDR_STATUS, d);
      check_word("status", 32'h9, d);
      if (exp_rec.size() < FIFO_DEPTH) begin
         $display("too few matches were produced for the overflow test");
         err_other++;
      end
      for (int k = 0; k < FIFO_DEPTH && k < exp_rec.size(); k++) begin
         reg_rd(ADDR_FIFO_DATA, d);
         check_entry("fifo hits", exp_rec[k], fifo_entry_t'(d[$bits(fifo_entry_t)-1:0]));
      end
      reg_rd(ADDR_STATUS, d);
      check_word("status", 32'hD, d);
      reg_wr(ADDR_CTRL, 32'h1);
      wait_state(cap_run);
      reg_rd(ADDR_STATUS, d);
      check_word("status", 32'h5, d);

      // one shot trigger
      reg_wr(ADDR_TRIG_DELAY, 7);
      reg_wr(ADDR_TRIG_WIDTH, 3);
      reg_wr(ADDR_CTRL, 32'h3);
      wait_state(cap_run);
      shift_nibble(1'b1, 4'hA);                // returns right after the shift edge
      n = 0;
      @(negedge trace_clk);
      while (!trig_out && n < 40) begin
         @(negedge trace_clk);
         n++;                                  // edges since the shift edge
      end
      if (!trig_out) begin
         $display("trigger output never went high");
         err_other++;
      end
      check_word("trig_out delay", 32'd9, n);
      n = 0;
      while (trig_out && n < 40) begin
         @(negedge trace_clk);
         n++;
      end
      check_word("trig_out width", 32'd3, n);
      for (int k = 0; k < 6; k++) shift_nibble(1'b1, 4'hA);
      drain();
      check_word("trig_out pulses", 32'd1, trig_rises);

      $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* trace_sniffer_top.f */
src/trace_pkg.sv
src/trace_matcher.sv
src/capture_ctrl.sv
src/trace_fifo.sv
src/pulse_trigger.sv
src/trace_regs.sv
src/trace_sniffer_top.sv
tb/trace_sniffer_checker.sv
tb/tb_trace_sniffer.sv

/* run_sim.sh */
#!/bin/bash
# build and run the trace sniffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f trace_sniffer_top.f \
   --top-module tb_trace_sniffer \
   -o sim

./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
exit 0
